// File: build.f
verilog/llc_cfg_pkg.sv
verilog/llc_cfg_regs.sv
verilog/llc_flush_ctrl.sv
verilog/llc_flush_counter.sv
verilog/llc_bypass_decode.sv
verilog/llc_config_top.sv
tb/tb_clk_gen.sv
tb/tb_llc_config.sv

// File: run.sh
#!/bin/sh
# Build and run the LLC configuration testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_llc_config -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb/tb_llc_config.sv
/* LLC configuration unit testbench */
`timescale 1ns/100ps

module tb_llc_config;
  import llc_cfg_pkg::*;

  // Six tests of about 200 cycles each
  localparam int unsigned CycleLimit = 6 * 200;

  logic        rst_ni;
  logic        arst_n_i;
  reg_req_t    req;
  reg_rsp_t    rsp;
  way_t        bist;
  logic        bist_valid;
  flush_desc_t desc;
  logic        desc_valid;
  logic        desc_ready;
  logic        desc_recv;
  logic        isolate;
  logic        isolated;
  logic        aw_busy;
  logic        ar_busy;
  addr_t       aw_addr;
  addr_t       ar_addr;
  logic        aw_bypass;
  logic        ar_bypass;
  way_t        spm_lock;

  int unsigned  cycles;
  int unsigned  n_checks;
  int unsigned  n_errors;
  int unsigned  n_order_errs;
  int unsigned  recv_pend;
  int unsigned  busy_cnt;
  logic         busy_long;
  logic [15:0]  lfsr_state;
  logic [2:0]   iso_pipe;
  logic         iso_seen;
  logic         iso_prev;
  flush_desc_t  exp_q[$];
  // Software view of the registers
  way_t         model_spm;
  way_t         model_flushed;

  tb_clk_gen i_clk (
    .clk_o    ( rst_ni   ),
    .arst_n_o ( arst_n_i )
  );

  llc_config_top dut (
    .rst_ni            ( rst_ni     ),
    .arst_n_i          ( arst_n_i   ),
    .req_i             ( req        ),
    .rsp_o             ( rsp        ),
    .bist_i            ( bist       ),
    .bist_valid_i      ( bist_valid ),
    .desc_o            ( desc       ),
    .desc_valid_o      ( desc_valid ),
    .desc_ready_i      ( desc_ready ),
    .flush_desc_recv_i ( desc_recv  ),
    .llc_isolate_o     ( isolate    ),
    .llc_isolated_i    ( isolated   ),
    .aw_unit_busy_i    ( aw_busy    ),
    .ar_unit_busy_i    ( ar_busy    ),
    .aw_addr_i         ( aw_addr    ),
    .ar_addr_i         ( ar_addr    ),
    .aw_bypass_o       ( aw_bypass  ),
    .ar_bypass_o       ( ar_bypass  ),
    .spm_lock_o        ( spm_lock   )
  );

  ////////////////////
  // Random source
  ////////////////////
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Ways that a commit flushes
  function automatic way_t pending_ways(way_t cfg_flush, way_t spm, way_t flushed);
    if (cfg_flush != '0) begin
      return cfg_flush & ~flushed;
    end
    return spm & ~flushed;
  endfunction

  // Flushed value after the commit completes
  function automatic way_t final_flushed(way_t cfg_flush, way_t spm, way_t flushed);
    if (pending_ways(cfg_flush, spm, flushed) != '0) begin
      return spm;
    end
    if (cfg_flush != '0) begin
      return flushed;
    end
    return spm & flushed;
  endfunction

  function automatic logic expected_bypass(addr_t addr, way_t flushed);
    if (addr >= 32'h9000_0000 && addr < 32'h9000_1000) begin
      return 1'b0;
    end
    if (addr >= 32'h8000_0000 && addr < 32'h8800_0000) begin
      return &flushed;
    end
    return 1'b1;
  endfunction

  function automatic flush_desc_t make_desc(int way, int line);
    flush_desc_t d;
    d.addr  = addr_t'(line) * 32;
    d.len   = 8'd3;
    d.way   = way_t'(1 << way);
    d.flush = 1'b1;
    return d;
  endfunction

  // Lowest way first, lines 0 to 7
  task automatic expect_descs(way_t cfg_flush, way_t spm, way_t flushed);
    way_t pend;
    pend = pending_ways(cfg_flush, spm, flushed);
    for (int w = 0; w < NumWays; w++) begin
      if (pend[w]) begin
        for (int l = 0; l < 8; l++) begin
          exp_q.push_back(make_desc(w, l));
        end
      end
    end
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_desc(flush_desc_t got, flush_desc_t exp, string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s got addr %h way %b expected addr %h way %b",
               $time, msg, got.addr, got.way, exp.addr, exp.way);
    end
  endtask

  task automatic check_word(data_t got, data_t exp, string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  ////////////////////
  // Register access
  ////////////////////
  task automatic reg_write(reg_addr_e a, data_t d);
    @(posedge rst_ni);
    req <= '{strobe: 1'b1, write: 1'b1, addr: a, data: d};
    @(posedge rst_ni);
    req <= '0;
  endtask

  task automatic read_check(reg_addr_e a, data_t exp, string msg);
    @(posedge rst_ni);
    req <= '{strobe: 1'b1, write: 1'b0, addr: a, data: '0};
    @(posedge rst_ni);
    req <= '0;
    // Response valid one cycle after the strobe
    @(negedge rst_ni);
    check_bit(rsp.valid, 1'b1, {msg, " valid"});
    check_word(rsp.data, exp, msg);
  endtask

  task automatic wait_isolate(logic level);
    do begin
      @(negedge rst_ni);
    end while (isolate !== level);
  endtask

  // Commit and wait for the end of the flush
  task automatic commit_flush(way_t cfg_flush);
    expect_descs(cfg_flush, model_spm, model_flushed);
    model_flushed = final_flushed(cfg_flush, model_spm, model_flushed);
    reg_write(RegCommit, 32'd1);
    wait_isolate(1'b1);
    wait_isolate(1'b0);
    check_word(data_t'(exp_q.size()), '0, "descriptors left over");
    read_check(RegFlushed, data_t'(model_flushed), "flushed");
    read_check(RegCfgFlush, '0, "cfg_flush cleared");
  endtask

  task automatic check_bypass(addr_t aw, addr_t ar);
    @(posedge rst_ni);
    aw_addr <= aw;
    ar_addr <= ar;
    @(negedge rst_ni);
    check_bit(aw_bypass, expected_bypass(aw, model_flushed), "aw bypass");
    check_bit(ar_bypass, expected_bypass(ar, model_flushed), "ar bypass");
  endtask

  task automatic report_test(string name, int unsigned errs);
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  ////////////////////
  // Cache-side responder
  ////////////////////
  always @(negedge rst_ni) begin
    iso_seen = isolate;
    // Isolation ordering
    if (desc_valid && (!isolated || aw_busy || ar_busy)) begin
      n_errors++;
      n_order_errs++;
      $display("Descriptor valid at %0t before the port was isolated and idle", $time);
    end
    if (desc_valid && desc_ready) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Unexpected flush descriptor at %0t, addr %h", $time, desc.addr);
      end else begin
        check_desc(desc, exp_q.pop_front(), "descriptor");
      end
      recv_pend++;
    end
  end

  always @(posedge rst_ni) begin
    logic [7:0] r;
    if (arst_n_i) begin
      iso_pipe <= {iso_pipe[1:0], iso_seen};
      isolated <= iso_pipe[2];
      // Short busy ends before the isolated rise, a long one after it
      if (iso_seen && !iso_prev) begin
        busy_long = ~busy_long;
        busy_cnt  = busy_long ? 8 : 1;
      end else if (busy_cnt != 0) begin
        busy_cnt--;
      end
      iso_prev = iso_seen;
      aw_busy <= (busy_cnt != 0);
      ar_busy <= (busy_cnt > 1);
      // Ready low on about a quarter of cycles
      take_bits(2, r);
      desc_ready <= (r[1:0] != 2'b11);
      take_bits(1, r);
      if (recv_pend != 0 && r[0]) begin
        desc_recv <= 1'b1;
        recv_pend--;
      end else begin
        desc_recv <= 1'b0;
      end
    end
  end

  // Watchdog
  always @(posedge rst_ni) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    int unsigned e;
    cycles        = 0;
    n_checks      = 0;
    n_errors      = 0;
    n_order_errs  = 0;
    recv_pend     = 0;
    busy_cnt      = 0;
    busy_long     = 1'b0;
    lfsr_state    = 16'd5;
    iso_seen      = 1'b0;
    iso_prev      = 1'b0;
    iso_pipe      <= '0;
    req           <= '0;
    bist          <= '0;
    bist_valid    <= 1'b0;
    desc_ready    <= 1'b0;
    desc_recv     <= 1'b0;
    isolated      <= 1'b0;
    aw_busy       <= 1'b0;
    ar_busy       <= 1'b0;
    aw_addr       <= '0;
    ar_addr       <= '0;
    @(posedge arst_n_i);
    repeat (3) @(posedge rst_ni);

    // BIST start-up
    e = n_errors;
    // Port held isolated until the BIST result arrives
    @(negedge rst_ni);
    check_bit(isolate, 1'b1, "isolate before BIST");
    @(posedge rst_ni);
    bist          <= 4'b0101;
    bist_valid    <= 1'b1;
    @(posedge rst_ni);
    bist_valid    <= 1'b0;
    model_spm     = 4'b0101;
    model_flushed = 4'b0101;
    // Isolation drops in the cycle after bist_valid
    @(negedge rst_ni);
    check_bit(isolate, 1'b0, "isolate after BIST");
    read_check(RegCfgSpm, 32'h5, "cfg_spm after BIST");
    read_check(RegFlushed, 32'h5, "flushed after BIST");
    read_check(RegBist, 32'h5, "BIST result");
    read_check(RegSetAsso, 32'd4, "set associativity");
    check_word(data_t'(spm_lock), 32'h5, "spm lock");
    report_test("1 bist start-up", n_errors - e);

    // Way flush of ways 1 and 3
    e = n_errors;
    reg_write(RegCfgFlush, 32'he);
    commit_flush(4'b1110);
    report_test("2 way flush", n_errors - e);

    // New SPM ways
    e = n_errors;
    reg_write(RegCfgSpm, 32'h3);
    model_spm = 4'b0011;
    commit_flush(4'b0000);
    read_check(RegCfgSpm, 32'h3, "cfg_spm read-back");
    report_test("3 spm reconfiguration", n_errors - e);

    // Bypass with partial and then full flushed state
    e = n_errors;
    check_bypass(32'h8000_1040, 32'h9000_0020);
    check_bypass(32'h4000_0000, 32'h87ff_fff8);
    check_bypass(32'h9000_0ffc, 32'h9000_1000);
    reg_write(RegCfgSpm, 32'hf);
    model_spm = 4'b1111;
    commit_flush(4'b0000);
    check_bypass(32'h8000_1040, 32'h9000_0020);
    check_bypass(32'h4000_0000, 32'h87ff_fff8);
    check_bypass(32'h9000_0ffc, 32'h9000_1000);
    report_test("5 bypass", n_errors - e);

    // CfgSpm write while isolated is dropped
    e = n_errors;
    reg_write(RegCfgFlush, 32'h1);
    expect_descs(4'b0001, model_spm, model_flushed);
    model_flushed = final_flushed(4'b0001, model_spm, model_flushed);
    reg_write(RegCommit, 32'd1);
    wait_isolate(1'b1);
    reg_write(RegCfgSpm, 32'h0);
    wait_isolate(1'b0);
    check_word(data_t'(exp_q.size()), '0, "descriptors left over");
    read_check(RegCfgSpm, 32'hf, "cfg_spm unchanged");
    read_check(RegFlushed, data_t'(model_flushed), "flushed unchanged");
    report_test("6 writes during flush", n_errors - e);

    // Ordering was watched during every flush
    report_test("4 isolation ordering", n_order_errs);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
/* Testbench clock and reset */
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held low for 10 cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// File: verilog/llc_config_top.sv
/* LLC configuration unit top */
`timescale 1ns/100ps

module llc_config_top (
  input  logic                     rst_ni,
  input  logic                     arst_n_i,
  // Register port
  input  llc_cfg_pkg::reg_req_t    req_i,
  output llc_cfg_pkg::reg_rsp_t    rsp_o,
  // Tag memory BIST
  input  llc_cfg_pkg::way_t        bist_i,
  input  logic                     bist_valid_i,
  // Flush descriptors
  output llc_cfg_pkg::flush_desc_t desc_o,
  output logic                     desc_valid_o,
  input  logic                     desc_ready_i,
  input  logic                     flush_desc_recv_i,
  // Slave port isolation
  output logic                     llc_isolate_o,
  input  logic                     llc_isolated_i,
  input  logic                     aw_unit_busy_i,
  input  logic                     ar_unit_busy_i,
  // Bypass steering
  input  llc_cfg_pkg::addr_t       aw_addr_i,
  input  llc_cfg_pkg::addr_t       ar_addr_i,
  output logic                     aw_bypass_o,
  output logic                     ar_bypass_o,
  output llc_cfg_pkg::way_t        spm_lock_o
);
  import llc_cfg_pkg::*;

  cfg_state_t  cfg_state;
  cfg_update_t cfg_upd;
  logic        commit;
  line_t       line;
  logic        send_last;
  logic        recv_last;
  logic        cnt_load;
  logic        cnt_send;
  logic        cnt_recv;

  llc_cfg_regs i_regs (
    .rst_ni       ( rst_ni       ),
    .arst_n_i     ( arst_n_i     ),
    .bist_i       ( bist_i       ),
    .bist_valid_i ( bist_valid_i ),
    .req_i        ( req_i        ),
    .upd_i        ( cfg_upd      ),
    .rsp_o        ( rsp_o        ),
    .commit_o     ( commit       ),
    .state_o      ( cfg_state    )
  );

  llc_flush_ctrl i_flush_ctrl (
    .rst_ni            ( rst_ni            ),
    .arst_n_i          ( arst_n_i          ),
    .commit_i          ( commit            ),
    .state_i           ( cfg_state         ),
    .bist_valid_i      ( bist_valid_i      ),
    .llc_isolated_i    ( llc_isolated_i    ),
    .aw_unit_busy_i    ( aw_unit_busy_i    ),
    .ar_unit_busy_i    ( ar_unit_busy_i    ),
    .flush_desc_recv_i ( flush_desc_recv_i ),
    .desc_ready_i      ( desc_ready_i      ),
    .line_i            ( line              ),
    .send_last_i       ( send_last         ),
    .recv_last_i       ( recv_last         ),
    .upd_o             ( cfg_upd           ),
    .llc_isolate_o     ( llc_isolate_o     ),
    .desc_o            ( desc_o            ),
    .desc_valid_o      ( desc_valid_o      ),
    .cnt_load_o        ( cnt_load          ),
    .cnt_send_o        ( cnt_send          ),
    .cnt_recv_o        ( cnt_recv          )
  );

  llc_flush_counter i_flush_counter (
    .rst_ni      ( rst_ni    ),
    .arst_n_i    ( arst_n_i  ),
    .load_i      ( cnt_load  ),
    .send_i      ( cnt_send  ),
    .recv_i      ( cnt_recv  ),
    .line_o      ( line      ),
    .send_last_o ( send_last ),
    .recv_last_o ( recv_last )
  );

  llc_bypass_decode i_bypass (
    .state_i     ( cfg_state   ),
    .aw_addr_i   ( aw_addr_i   ),
    .ar_addr_i   ( ar_addr_i   ),
    .aw_bypass_o ( aw_bypass_o ),
    .ar_bypass_o ( ar_bypass_o )
  );

  // SPM lock toward the tag lookup
  assign spm_lock_o = cfg_state.cfg_spm;

endmodule

// File: verilog/llc_bypass_decode.sv
/* LLC bypass decision */
`timescale 1ns/100ps

module llc_bypass_decode (
  input  llc_cfg_pkg::cfg_state_t state_i,
  input  llc_cfg_pkg::addr_t      aw_addr_i,
  input  llc_cfg_pkg::addr_t      ar_addr_i,
  output logic                    aw_bypass_o,
  output logic                    ar_bypass_o
);
  import llc_cfg_pkg::*;

  // Region rule for one address channel
  function automatic logic bypass(addr_t addr, way_t flushed);
    logic in_spm;
    logic in_cached;
    in_spm    = (addr >= SpmStart) && (addr < SpmEnd);
    in_cached = (addr >= CachedStart) && (addr < CachedEnd);
    if (in_spm) begin
      // SPM always served by the cache
      bypass = 1'b0;
    end else if (in_cached) begin
      // Cache fully flushed, go straight to memory
      bypass = &flushed;
    end else begin
      // Unmapped addresses take the bypass
      bypass = 1'b1;
    end
  endfunction

  ////////////////////
  // AW and AR
  ////////////////////
  assign aw_bypass_o = bypass(aw_addr_i, state_i.flushed);
  assign ar_bypass_o = bypass(ar_addr_i, state_i.flushed);

endmodule

// File: verilog/llc_flush_counter.sv
/* Flush line counters */
`timescale 1ns/100ps

module llc_flush_counter (
  input  logic               rst_ni,
  input  logic               arst_n_i,
  input  logic               load_i,
  input  logic               send_i,
  input  logic               recv_i,
  output llc_cfg_pkg::line_t line_o,
  output logic               send_last_o,
  output logic               recv_last_o
);
  import llc_cfg_pkg::*;

  // Line index of the next descriptor
  line_t send_q;
  // Completions still expected, minus one
  line_t outst_q;

  ////////////////////
  // Send counter
  ////////////////////
  always_ff @(posedge rst_ni or negedge arst_n_i) begin
    if (!arst_n_i) begin
      send_q <= '0;
    end else if (load_i) begin
      send_q <= '0;
    end else if (send_i) begin
      // Wraps after the last line
      send_q <= send_q + line_t'(1);
    end
  end

  ////////////////////
  // Completion counter
  ////////////////////
  always_ff @(posedge rst_ni or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outst_q <= '0;
    end else if (load_i) begin
      outst_q <= line_t'(NumLines - 1);
    end else if (recv_i) begin
      outst_q <= outst_q - line_t'(1);
    end
  end

  assign line_o      = send_q;
  // Current descriptor is the last line of the way
  assign send_last_o = (send_q == line_t'(NumLines - 1));
  // Next completion closes the way
  assign recv_last_o = (outst_q == '0);

endmodule

// File: verilog/llc_flush_ctrl.sv
/* LLC way flush control */
`timescale 1ns/100ps

module llc_flush_ctrl (
  input  logic                     rst_ni,
  input  logic                     arst_n_i,
  input  logic                     commit_i,
  input  llc_cfg_pkg::cfg_state_t  state_i,
  input  logic                     bist_valid_i,
  input  logic                     llc_isolated_i,
  input  logic                     aw_unit_busy_i,
  input  logic                     ar_unit_busy_i,
  input  logic                     flush_desc_recv_i,
  input  logic                     desc_ready_i,
  input  llc_cfg_pkg::line_t       line_i,
  input  logic                     send_last_i,
  input  logic                     recv_last_i,
  output llc_cfg_pkg::cfg_update_t upd_o,
  output logic                     llc_isolate_o,
  output llc_cfg_pkg::flush_desc_t desc_o,
  output logic                     desc_valid_o,
  output logic                     cnt_load_o,
  output logic                     cnt_send_o,
  output logic                     cnt_recv_o
);
  import llc_cfg_pkg::*;

  flush_state_e state_d;
  flush_state_e state_q;
  // Ways still waiting for their flush
  way_t         pending_d;
  way_t         pending_q;
  // One-hot way under flush
  way_t         way_sel;
  logic         way_is_last;

  ////////////////////
  // Way selection
  ////////////////////
  // Isolate the lowest set bit
  assign way_sel     = pending_q & (~pending_q + way_t'(1));
  assign way_is_last = (pending_q == way_sel);

  // Descriptor payload, one line of the selected way
  assign desc_o.addr  = addr_t'(line_i) << IndexBase;
  assign desc_o.len   = 8'(NumBlocks - 1);
  assign desc_o.way   = way_sel;
  assign desc_o.flush = 1'b1;

  ////////////////////
  // Flush FSM
  ////////////////////
  always_comb begin
    state_d          = state_q;
    pending_d        = pending_q;
    upd_o.flushed    = state_i.flushed;
    upd_o.flushed_en = 1'b0;
    upd_o.spm        = state_i.cfg_spm;
    upd_o.spm_en     = 1'b0;
    upd_o.clr_flush  = 1'b0;
    // Software config is locked outside Idle
    upd_o.busy       = (state_q != Idle);
    cnt_load_o       = 1'b0;

    case (state_q)
      PreInit: begin
        // BIST result seeds SPM lock and flushed state
        if (bist_valid_i) begin
          upd_o.spm        = state_i.bist;
          upd_o.spm_en     = 1'b1;
          upd_o.flushed    = state_i.bist;
          upd_o.flushed_en = 1'b1;
          state_d          = Idle;
        end
      end
      Idle: begin
        if (commit_i) begin
          state_d = WaitAx;
        end
      end
      WaitAx: begin
        // Slave port must be quiet
        if (llc_isolated_i) begin
          state_d = WaitUnits;
        end
      end
      WaitUnits: begin
        // No descriptor left in the AW and AR units
        if (!aw_unit_busy_i && !ar_unit_busy_i) begin
          state_d = InitFlush;
        end
      end
      InitFlush: begin
        if (|state_i.cfg_flush) begin
          // Explicit way flush request
          pending_d = state_i.cfg_flush & ~state_i.flushed;
        end else begin
          // SPM change, flush newly locked ways
          pending_d        = state_i.cfg_spm & ~state_i.flushed;
          upd_o.flushed    = state_i.cfg_spm & state_i.flushed;
          upd_o.flushed_en = 1'b1;
        end
        if (pending_d == '0) begin
          upd_o.clr_flush = 1'b1;
          state_d         = Idle;
        end else begin
          cnt_load_o = 1'b1;
          state_d    = SendFlush;
        end
      end
      SendFlush: begin
        // Last line of this way accepted
        if (desc_ready_i && send_last_i) begin
          state_d = WaitFlush;
        end
      end
      WaitFlush: begin
        if (flush_desc_recv_i && recv_last_i) begin
          state_d = EndFlush;
        end
      end
      EndFlush: begin
        if (way_is_last) begin
          // All done, flushed falls back to SPM ways
          upd_o.flushed    = state_i.cfg_spm;
          upd_o.flushed_en = 1'b1;
          upd_o.clr_flush  = 1'b1;
          pending_d        = '0;
          state_d          = Idle;
        end else begin
          upd_o.flushed    = state_i.flushed | way_sel;
          upd_o.flushed_en = 1'b1;
          state_d          = InitFlush;
        end
      end
      default: begin
        state_d = PreInit;
      end
    endcase
  end

  always_ff @(posedge rst_ni or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= PreInit;
      pending_q <= '0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////
  // Port stays isolated for start-up and every flush
  assign llc_isolate_o = (state_q != Idle);
  assign desc_valid_o  = (state_q == SendFlush);
  assign cnt_send_o    = desc_valid_o & desc_ready_i;
  // Completions may overlap with sending
  assign cnt_recv_o    = flush_desc_recv_i &
                         ((state_q == SendFlush) || (state_q == WaitFlush));

endmodule

// File: verilog/llc_cfg_regs.sv
/* LLC configuration register file */
`timescale 1ns/100ps

module llc_cfg_regs (
  input  logic                     rst_ni,
  input  logic                     arst_n_i,
  input  llc_cfg_pkg::way_t        bist_i,
  input  logic                     bist_valid_i,
  input  llc_cfg_pkg::reg_req_t    req_i,
  input  llc_cfg_pkg::cfg_update_t upd_i,
  output llc_cfg_pkg::reg_rsp_t    rsp_o,
  output logic                     commit_o,
  output llc_cfg_pkg::cfg_state_t  state_o
);
  import llc_cfg_pkg::*;

  way_t  cfg_spm_q;
  way_t  cfg_flush_q;
  way_t  flushed_q;
  way_t  bist_q;
  way_t  wr_way;
  logic  sw_wr;
  logic  sw_wr_ok;
  logic  commit_q;
  logic  rsp_valid_q;
  data_t rdata_d;
  data_t rdata_q;

  // Decoded software access
  assign sw_wr    = req_i.strobe & req_i.write;
  // Config writes only land while no flush runs
  assign sw_wr_ok = sw_wr & ~upd_i.busy;
  assign wr_way   = req_i.data[NumWays-1:0];

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge rst_ni or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_spm_q   <= '0;
      cfg_flush_q <= '0;
      flushed_q   <= '0;
      bist_q      <= '0;
      commit_q    <= 1'b0;
    end else begin
      // Hardware update wins over software
      if (upd_i.spm_en) begin
        cfg_spm_q <= upd_i.spm;
      end else if (sw_wr_ok && req_i.addr == RegCfgSpm) begin
        cfg_spm_q <= wr_way;
      end
      if (upd_i.clr_flush) begin
        cfg_flush_q <= '0;
      end else if (sw_wr_ok && req_i.addr == RegCfgFlush) begin
        cfg_flush_q <= wr_way;
      end
      // Read-only for software
      if (upd_i.flushed_en) begin
        flushed_q <= upd_i.flushed;
      end
      if (bist_valid_i) begin
        bist_q <= bist_i;
      end
      // One-cycle commit pulse
      commit_q <= sw_wr_ok && (req_i.addr == RegCommit);
    end
  end

  ////////////////////
  // Read path
  ////////////////////
  always_comb begin
    case (req_i.addr)
      RegCfgSpm:   rdata_d = data_t'(cfg_spm_q);
      RegCfgFlush: rdata_d = data_t'(cfg_flush_q);
      RegFlushed:  rdata_d = data_t'(flushed_q);
      RegBist:     rdata_d = data_t'(bist_q);
      RegSetAsso:  rdata_d = data_t'(NumWays);
      // Commit always reads zero
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge rst_ni or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.strobe & ~req_i.write;
    end
  end

  always_ff @(posedge rst_ni) begin
    rdata_q <= rdata_d;
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.data  = rdata_q;
  assign commit_o    = commit_q;

  assign state_o.cfg_spm   = cfg_spm_q;
  assign state_o.cfg_flush = cfg_flush_q;
  assign state_o.flushed   = flushed_q;
  // Forward the BIST result in its capture cycle
  assign state_o.bist      = bist_valid_i ? bist_i : bist_q;

endmodule

// File: verilog/llc_cfg_pkg.sv
/* LLC configuration and flush package */
package llc_cfg_pkg;

  ////////////////////
  // Cache geometry
  ////////////////////
  localparam int unsigned NumWays           = 4;
  localparam int unsigned IndexLength       = 3;
  localparam int unsigned NumLines          = 1 << IndexLength;
  localparam int unsigned ByteOffsetLength  = 3;
  localparam int unsigned BlockOffsetLength = 2;
  // Bit position of the line index inside an address
  localparam int unsigned IndexBase         = ByteOffsetLength + BlockOffsetLength;
  localparam int unsigned NumBlocks         = 1 << BlockOffsetLength;
  localparam int unsigned AddrWidth         = 32;
  localparam int unsigned RegWidth          = 32;

  typedef logic [NumWays-1:0]     way_t;
  typedef logic [IndexLength-1:0] line_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [RegWidth-1:0]    data_t;

  // Address regions, end addresses exclusive
  // Cached region sits below the SPM region
  localparam addr_t CachedStart = 32'h8000_0000;
  localparam addr_t CachedEnd   = 32'h8800_0000;
  localparam addr_t SpmStart    = 32'h9000_0000;
  localparam addr_t SpmEnd      = 32'h9000_1000;

  ////////////////////
  // Register port
  ////////////////////
  typedef enum logic [2:0] {
    RegCfgSpm   = 3'd0,
    RegCfgFlush = 3'd1,
    RegCommit   = 3'd2,
    RegFlushed  = 3'd3,
    RegBist     = 3'd4,
    RegSetAsso  = 3'd5
  } reg_addr_e;

  typedef struct packed {
    logic      strobe;
    logic      write;
    reg_addr_e addr;
    data_t     data;
  } reg_req_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } reg_rsp_t;

  // One flush descriptor per cache line
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    way_t       way;
    logic       flush;
  } flush_desc_t;

  // Register contents seen by hardware
  typedef struct packed {
    way_t cfg_spm;
    way_t cfg_flush;
    way_t flushed;
    way_t bist;
  } cfg_state_t;

  // Hardware writes into the register file
  typedef struct packed {
    way_t flushed;
    logic flushed_en;
    way_t spm;
    logic spm_en;
    logic clr_flush;
    logic busy;
  } cfg_update_t;

  typedef enum logic [2:0] {
    PreInit,
    Idle,
    WaitAx,
    WaitUnits,
    InitFlush,
    SendFlush,
    WaitFlush,
    EndFlush
  } flush_state_e;

endpackage
